//--- cpu_cfg.svh
// cpu configuration: field widths, register count, opcodes and reset pc
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ****************************************
// widths
// ****************************************
`define CPU_DATA_W      32
`define CPU_PC_W        8
`define CPU_INSTR_W     16
`define CPU_REG_ADDR_W  4
`define CPU_NUM_REGS    16
`define CPU_IMM_W       8
`define CPU_SHAMT_W     5   // low bits of operand b
`define CPU_ZTEST_W     8   // branch zero test looks at these only

// ****************************************
// opcodes, top nibble of the instruction
// ****************************************
`define CPU_OP_JZ       4'b1000
`define CPU_OP_JNZ      4'b1001
`define CPU_OP_LOADI    4'b1010
`define CPU_OP_STOP     4'b1111

`define CPU_RESET_PC    8'h00

`endif

//--- cpu_pkg.sv
// cpu types: data, address and instruction words, alu operation codes
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

   localparam int cpu_word_bits = `CPU_DATA_W;

   typedef logic [`CPU_DATA_W-1:0]     data_t;
   typedef logic [`CPU_PC_W-1:0]       pc_t;
   typedef logic [`CPU_INSTR_W-1:0]    instr_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`CPU_IMM_W-1:0]      imm_t;

   // bits 14:12 of an alu group instruction
   typedef enum logic [2:0] {
      alu_sll  = 3'd0,
      alu_srl  = 3'd1,
      alu_add  = 3'd2,
      alu_sub  = 3'd3,
      alu_and  = 3'd4,
      alu_xnor = 3'd5,
      alu_rsv6 = 3'd6,   // was divide
      alu_rsv7 = 3'd7
   } alu_op_e;

endpackage

`default_nettype wire

//--- ctrl_if.sv
// decoded control bundle from the instruction decoder to the datapath blocks
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

   logic                write_en;
   logic                imm_en;
   logic                jz_en;
   logic                jnz_en;
   logic                stop_en;
   cpu_pkg::reg_addr_t  addr_s;
   cpu_pkg::reg_addr_t  addr_a;
   cpu_pkg::reg_addr_t  addr_b;
   cpu_pkg::alu_op_e    alu_op;
   cpu_pkg::imm_t       imm;
   cpu_pkg::pc_t        branch_pc;

   modport dec (
      output write_en, imm_en, jz_en, jnz_en, stop_en,
      output addr_s, addr_a, addr_b, alu_op, imm, branch_pc
   );

   modport pc (input jz_en, jnz_en, stop_en, branch_pc);

   modport rf (input write_en, addr_s, addr_a, addr_b);

   modport ex (input alu_op, imm_en, imm);

endinterface

`default_nettype wire

//--- instr_decoder.sv
// instruction decoder: field slicing and instruction class strobes
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instr_decoder (
   input  cpu_pkg::instr_t code,
   ctrl_if.dec             ctl
);

   logic [3:0] opcode;
   logic       alu_grp;
   logic       alu_valid;

   assign opcode = code[15:12];
   assign alu_grp = ~code[15];

   // ****************************************
   // fields, sliced the same for every class
   // ****************************************
   assign ctl.alu_op    = cpu_pkg::alu_op_e'(code[14:12]);
   assign ctl.addr_s    = code[11:8];
   assign ctl.addr_a    = code[7:4];
   assign ctl.addr_b    = code[3:0];
   assign ctl.imm       = code[7:0];
   assign ctl.branch_pc = {code[11:8], code[3:0]};   // target split around rega

   // ****************************************
   // class strobes
   // ****************************************
   // reserved codes behave as nop
   assign alu_valid = (ctl.alu_op != cpu_pkg::alu_rsv6) &&
                      (ctl.alu_op != cpu_pkg::alu_rsv7);

   assign ctl.imm_en   = (opcode == `CPU_OP_LOADI);
   assign ctl.jz_en    = (opcode == `CPU_OP_JZ);
   assign ctl.jnz_en   = (opcode == `CPU_OP_JNZ);
   assign ctl.stop_en  = (opcode == `CPU_OP_STOP);
   assign ctl.write_en = ctl.imm_en | (alu_grp & alu_valid);

endmodule

`default_nettype wire

//--- pc_unit.sv
// program counter with branch decision and next pc select
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module pc_unit (
   input  logic           clk,
   input  logic           rst_n,
   ctrl_if.pc             ctl,
   input  cpu_pkg::data_t a,
   output cpu_pkg::pc_t   pc,
   output cpu_pkg::pc_t   next_pc,
   output logic           branch_en
);

   logic         a_zero;
   cpu_pkg::pc_t inc_pc;

   // only the low byte of rega is tested
   assign a_zero = ~|a[`CPU_ZTEST_W-1:0];

   assign branch_en = (ctl.jz_en & a_zero) | (ctl.jnz_en & ~a_zero);

   assign inc_pc = pc + 1'b1;   // wraps at 256

   // ****************************************
   // next pc
   // ****************************************
   always_comb begin
      if (!rst_n) begin
         next_pc = `CPU_RESET_PC;
      end else if (ctl.stop_en) begin
         next_pc = pc;   // hold until reset
      end else if (branch_en) begin
         next_pc = ctl.branch_pc;
      end else begin
         next_pc = inc_pc;
      end
   end

   // reset value arrives through next_pc
   always_ff @(posedge clk) begin
      pc <= next_pc;
   end

endmodule

`default_nettype wire

//--- reg_file.sv
// register file: 16 x 32, two combinational read ports, one clocked write port
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file (
   input  logic           clk,
   input  logic           rst_n,
   ctrl_if.rf             ctl,
   input  cpu_pkg::data_t result,
   output cpu_pkg::data_t a,
   output cpu_pkg::data_t b
);

   cpu_pkg::data_t regs [`CPU_NUM_REGS];

   // no bypass, same-cycle read sees the old word
   assign a = regs[ctl.addr_a];
   assign b = regs[ctl.addr_b];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (ctl.write_en) begin
         regs[ctl.addr_s] <= result;
      end
   end

endmodule

`default_nettype wire

//--- execute_unit.sv
// execute stage: alu and the immediate or alu result select
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module execute_unit (
   ctrl_if.ex             ctl,
   input  cpu_pkg::data_t a,
   input  cpu_pkg::data_t b,
   output cpu_pkg::data_t result
);

   logic [`CPU_SHAMT_W-1:0] shamt;
   cpu_pkg::data_t          alu_res;
   cpu_pkg::data_t          imm_ext;

   assign shamt = b[`CPU_SHAMT_W-1:0];

   // ****************************************
   // alu
   // ****************************************
   always_comb begin
      case (ctl.alu_op)
         cpu_pkg::alu_sll:  alu_res = a << shamt;
         cpu_pkg::alu_srl:  alu_res = a >> shamt;
         cpu_pkg::alu_add:  alu_res = a + b;   // modulo 2^32, no carry out
         cpu_pkg::alu_sub:  alu_res = a - b;
         cpu_pkg::alu_and:  alu_res = a & b;
         cpu_pkg::alu_xnor: alu_res = ~(a ^ b);
         default:           alu_res = '0;      // reserved, never written
      endcase
   end

   // loadi zero extends
   assign imm_ext = {{(`CPU_DATA_W-`CPU_IMM_W){1'b0}}, ctl.imm};

   assign result = ctl.imm_en ? imm_ext : alu_res;

endmodule

`default_nettype wire

//--- cpu_top.sv
// single-cycle 32-bit cpu top: decoder, pc, register file and execute stage
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
   input  logic            clk,
   input  logic            rst_n,
   input  cpu_pkg::instr_t code,
   output cpu_pkg::pc_t    pc,
   output cpu_pkg::pc_t    next_pc,
   output cpu_pkg::data_t  mem_s,
   output logic            write_en,
   output logic            imm_en,
   output logic            branch_en
);

   cpu_pkg::data_t a;
   cpu_pkg::data_t b;

   ctrl_if u_ctl ();

   instr_decoder u_dec (
      .code (code),
      .ctl  (u_ctl.dec)
   );

   pc_unit u_pc (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctl       (u_ctl.pc),
      .a         (a),          // zero test operand
      .pc        (pc),
      .next_pc   (next_pc),
      .branch_en (branch_en)
   );

   reg_file u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctl    (u_ctl.rf),
      .result (mem_s),
      .a      (a),
      .b      (b)
   );

   execute_unit u_ex (
      .ctl    (u_ctl.ex),
      .a      (a),
      .b      (b),
      .result (mem_s)
   );

   assign write_en = u_ctl.write_en;
   assign imm_en   = u_ctl.imm_en;

endmodule

`default_nettype wire

//--- cpu_assertions.sv
// cpu checker: pc sequencing, branch and write exclusivity, stop hold
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_assertions (
   input logic            clk,
   input logic            rst_n,
   input cpu_pkg::instr_t code,
   input cpu_pkg::pc_t    pc,
   input cpu_pkg::pc_t    next_pc,
   input logic            write_en,
   input logic            branch_en
);

   int unsigned fail_count = 0;   // failed assertions so far

   pc_follows_next: assert property (@(posedge clk)
      (rst_n && $past(rst_n)) |-> (pc == $past(next_pc)))
      else begin
         $error("pc does not hold the previous next_pc");
         fail_count++;
      end

   // a branch never writes a register
   branch_no_write: assert property (@(posedge clk)
      (rst_n && branch_en) |-> !write_en)
      else begin
         $error("branch_en and write_en high together");
         fail_count++;
      end

   stop_holds_pc: assert property (@(posedge clk)
      (rst_n && code[15:12] == `CPU_OP_STOP) |-> (next_pc == pc))
      else begin
         $error("stop does not hold pc");
         fail_count++;
      end

   pc_zero_after_reset: assert property (@(posedge clk)
      (rst_n && !$past(rst_n)) |-> (pc == `CPU_RESET_PC))
      else begin
         $error("pc not at reset value after reset");
         fail_count++;
      end

endmodule

bind cpu_top cpu_assertions u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .code      (code),
   .pc        (pc),
   .next_pc   (next_pc),
   .write_en  (write_en),
   .branch_en (branch_en)
);

`default_nettype wire

//--- tb_cpu_top.sv
// cpu testbench: random program, instruction-set model and per-cycle compare
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_top;

   localparam int clk_period     = 8;
   localparam int rst_cycles     = 5;
   localparam int n_instr        = 2000;
   localparam int stop_wait      = 3;
   localparam int prog_depth     = 256;
   localparam int timeout_cycles = rst_cycles + n_instr * 2;

   // one step of the instruction set
   typedef struct packed {
      cpu_pkg::data_t     result;
      cpu_pkg::reg_addr_t dest;
      logic               write_en;
      logic               imm_en;
      logic               branch_en;
      logic               stop;
      cpu_pkg::pc_t       next_pc;
   } step_t;

   logic            clk = 1'b0;
   logic            rst_n;
   cpu_pkg::instr_t code;
   cpu_pkg::pc_t    pc;
   cpu_pkg::pc_t    next_pc;
   cpu_pkg::data_t  mem_s;
   logic            write_en;
   logic            imm_en;
   logic            branch_en;

   cpu_pkg::instr_t prog [prog_depth];
   cpu_pkg::data_t  shadow_regs [`CPU_NUM_REGS];
   cpu_pkg::pc_t    shadow_pc;
   step_t           exp_step;
   int              executed;
   int              stop_cycles;
   int              restarts;

   cpu_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .code      (code),
      .pc        (pc),
      .next_pc   (next_pc),
      .mem_s     (mem_s),
      .write_en  (write_en),
      .imm_en    (imm_en),
      .branch_en (branch_en)
   );

   always #(clk_period / 2) clk = ~clk;

   // ****************************************
   // reference model
   // ****************************************
   function automatic step_t isa_step(input cpu_pkg::instr_t instr);
      step_t          s;
      cpu_pkg::data_t ra;
      cpu_pkg::data_t rb;
      logic [4:0]     sh;
      logic           zero;
      s    = '0;
      ra   = shadow_regs[instr[7:4]];
      rb   = shadow_regs[instr[3:0]];
      sh   = rb[4:0];
      zero = (ra[7:0] == 8'h00);   // low byte only
      s.dest    = instr[11:8];
      s.next_pc = shadow_pc + 8'd1;
      if (instr[15] == 1'b0) begin
         s.write_en = (instr[14:12] < 3'd6);
         case (instr[14:12])
            3'd0:    s.result = ra << sh;
            3'd1:    s.result = ra >> sh;
            3'd2:    s.result = ra + rb;
            3'd3:    s.result = ra - rb;
            3'd4:    s.result = ra & rb;
            3'd5:    s.result = ~(ra ^ rb);
            default: s.result = '0;
         endcase
      end else begin
         case (instr[15:12])
            `CPU_OP_LOADI: begin
               s.write_en = 1'b1;
               s.imm_en   = 1'b1;
               s.result   = cpu_pkg::data_t'(instr[7:0]);
            end
            `CPU_OP_JZ:   s.branch_en = zero;
            `CPU_OP_JNZ:  s.branch_en = ~zero;
            `CPU_OP_STOP: s.stop = 1'b1;
            default: ;
         endcase
         if (s.stop) begin
            s.next_pc = shadow_pc;
         end else if (s.branch_en) begin
            s.next_pc = {instr[11:8], instr[3:0]};
         end
      end
      return s;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input cpu_pkg::data_t expected,
                               input cpu_pkg::data_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED at %0t: %s expected %0d'h%h actual %0d'h%h",
                             $time, name, cpu_pkg::cpu_word_bits, expected,
                             cpu_pkg::cpu_word_bits, actual));
      end
   endtask

   task automatic compare_pc(input string name, input cpu_pkg::pc_t expected,
                             input cpu_pkg::pc_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED at %0t: %s expected %h actual %h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic compare_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         abort_run($sformatf("FAILED at %0t: %s expected %b actual %b",
                             $time, name, expected, actual));
      end
   endtask

   task automatic build_program();
      int unsigned        pick;
      cpu_pkg::reg_addr_t r;
      prog[0] = {1'b0, 3'd2, 4'd0, 4'd1, 4'd2};   // add on cleared registers
      for (int i = 1; i <= `CPU_NUM_REGS; i++) begin
         r       = cpu_pkg::reg_addr_t'(i - 1);
         prog[i] = {`CPU_OP_LOADI, r, 8'($urandom)};
      end
      for (int i = `CPU_NUM_REGS + 1; i < prog_depth; i++) begin
         pick = $urandom % 64;
         if (pick < 16) begin
            prog[i] = {`CPU_OP_LOADI, 12'($urandom)};
         end else if (pick < 40) begin
            prog[i] = {1'b0, 15'($urandom)};   // reserved codes too
         end else if (pick < 51) begin
            prog[i] = {`CPU_OP_JZ, 12'($urandom)};
         end else if (pick < 62) begin
            prog[i] = {`CPU_OP_JNZ, 12'($urandom)};
         end else begin
            prog[i] = {`CPU_OP_STOP, 12'h000};
         end
      end
   endtask

   task automatic apply_reset();
      rst_n <= 1'b0;
      code  <= prog[0];
      repeat (rst_cycles) @(posedge clk);
      rst_n <= 1'b1;
      foreach (shadow_regs[i]) begin
         shadow_regs[i] = '0;
      end
      shadow_pc = `CPU_RESET_PC;
   endtask

   // ****************************************
   // compare, just before each rising edge
   // ****************************************
   always begin
      @(posedge clk);
      #(clk_period - 1);
      if (rst_n === 1'b1) begin
         exp_step = isa_step(code);
         compare_pc("pc", shadow_pc, pc);
         compare_pc("next_pc", exp_step.next_pc, next_pc);
         compare_bit("write_en", exp_step.write_en, write_en);
         compare_bit("imm_en", exp_step.imm_en, imm_en);
         compare_bit("branch_en", exp_step.branch_en, branch_en);
         if (exp_step.write_en) begin
            compare_word("mem_s", exp_step.result, mem_s);
         end
      end
   end

   // bound checker failures end the run at once
   always @(u_dut.u_chk.fail_count) begin
      if (u_dut.u_chk.fail_count != 0) begin
         abort_run("a bound assertion on the cpu failed");
      end
   end

   initial begin
      #(timeout_cycles * clk_period);
      abort_run("run timed out before all instructions had executed");
   end

   initial begin
      rst_n = 1'b0;
      code  = '0;
      void'($urandom(99506));
      build_program();
      executed    = 0;
      stop_cycles = 0;
      restarts    = 0;
      apply_reset();
      while (executed < n_instr) begin
         @(posedge clk);
         if (exp_step.write_en) begin
            shadow_regs[exp_step.dest] = exp_step.result;
         end
         shadow_pc   = exp_step.next_pc;
         executed++;
         stop_cycles = exp_step.stop ? stop_cycles + 1 : 0;
         if (stop_cycles > stop_wait) begin   // stop held long enough, restart
            stop_cycles = 0;
            restarts++;
            apply_reset();
         end else begin
            code <= prog[shadow_pc];
         end
      end
      @(negedge clk);   // last edge's assertions have run
      if (u_dut.u_chk.fail_count != 0) begin
         abort_run("a bound assertion on the cpu failed");
      end else begin
         $display("%0d instructions, %0d restarts after stop", executed, restarts);
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
cpu_pkg.sv
ctrl_if.sv
instr_decoder.sv
pc_unit.sv
reg_file.sv
execute_unit.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu_top.sv
